//--- verilog/mesh_cfg_pkg.sv
`default_nettype none

package mesh_cfg_pkg;

  // ----------------------------------------
  // mesh geometry
  // ----------------------------------------

  // two columns of nodes
  localparam int num_cols_c = 2;
  // three rows, row 0 being the i/o row
  localparam int num_rows_c = 3;
  // row index of the i/o routers
  localparam int io_row_c = 0;

  // router port count, local port plus four mesh links
  localparam int num_dirs_c = 5;

  // per tile data memory depth in words
  localparam int dmem_words_c = 16;

  // ----------------------------------------
  // coordinates and ids
  // ----------------------------------------

  // column index
  typedef logic [0:0] x_cord_t;
  // row index, covers the i/o row too
  typedef logic [1:0] y_cord_t;

  // port directions, local port first
  // y grows toward S, so the i/o row is the northmost row
  typedef enum logic [2:0] {P = 3'd0, W, E, N, S} dir_e;

  // word address inside one tile memory
  typedef logic [3:0] dmem_addr_t;
  // tag carried by a load and echoed in its reply
  typedef logic [4:0] load_id_t;

endpackage

`default_nettype wire

//--- verilog/mesh_pkt_pkg.sv
`default_nettype none

package mesh_pkt_pkg;

  // ----------------------------------------
  // packet fields
  // ----------------------------------------

  // payload word width
  localparam int data_width_c = 32;

  // zero padding that fills the load control view up to one word
  localparam int ld_pad_w_c = data_width_c
                              - $bits(mesh_cfg_pkg::x_cord_t)
                              - $bits(mesh_cfg_pkg::y_cord_t)
                              - $bits(mesh_cfg_pkg::load_id_t);

  // packet opcode
  typedef enum logic [1:0] {
    op_store = 2'd0,
    op_load  = 2'd1,
    op_reply = 2'd2
  } pkt_op_e;

  // load payload, tells the endpoint where to send the reply
  typedef struct packed {
    logic [ld_pad_w_c-1:0]    pad;
    mesh_cfg_pkg::x_cord_t    reply_x;
    mesh_cfg_pkg::y_cord_t    reply_y;
    mesh_cfg_pkg::load_id_t   load_id;
  } ld_ctrl_s;

  // one payload word, read as data for store and reply,
  // as reply routing info for load
  typedef union packed {
    logic [data_width_c-1:0]  data;
    ld_ctrl_s                 ld;
  } payload_u;

  // ----------------------------------------
  // packet and link
  // ----------------------------------------

  // load_id only means something in a reply
  typedef struct packed {
    pkt_op_e                  op;
    mesh_cfg_pkg::x_cord_t    dest_x;
    mesh_cfg_pkg::y_cord_t    dest_y;
    mesh_cfg_pkg::dmem_addr_t addr;
    mesh_cfg_pkg::load_id_t   load_id;
    payload_u                 payload;
  } mesh_pkt_s;

  // forward half of a link, ready travels back separately
  typedef struct packed {
    logic      v;
    mesh_pkt_s pkt;
  } link_fwd_s;

endpackage

`default_nettype wire

//--- verilog/mesh_router.sv
`timescale 1ns/1ps
`default_nettype none

module mesh_router (
  input  logic                                                      clk_i,
  input  logic                                                      rst_i,
  input  mesh_cfg_pkg::x_cord_t                                     my_x_i,
  input  mesh_cfg_pkg::y_cord_t                                     my_y_i,
  input  mesh_pkt_pkg::link_fwd_s [mesh_cfg_pkg::S:mesh_cfg_pkg::P] fwd_i,
  output logic [mesh_cfg_pkg::S:mesh_cfg_pkg::P]                    rdy_o,
  output mesh_pkt_pkg::link_fwd_s [mesh_cfg_pkg::S:mesh_cfg_pkg::P] fwd_o,
  input  logic [mesh_cfg_pkg::S:mesh_cfg_pkg::P]                    rdy_i
);

  // one entry buffer per input
  mesh_pkt_pkg::mesh_pkt_s [mesh_cfg_pkg::S:mesh_cfg_pkg::P] buf_pkt_r;
  logic [mesh_cfg_pkg::S:mesh_cfg_pkg::P]                    buf_v_r;
  logic [mesh_cfg_pkg::S:mesh_cfg_pkg::P]                    buf_v_nxt;
  // registered ready, low through reset and while a buffer is full
  logic [mesh_cfg_pkg::S:mesh_cfg_pkg::P]                    rdy_r;
  logic [mesh_cfg_pkg::S:mesh_cfg_pkg::P]                    accept;

  // requested output of each buffered packet
  mesh_cfg_pkg::dir_e [mesh_cfg_pkg::S:mesh_cfg_pkg::P]      route_dir;

  // per output round robin state and grant
  logic [mesh_cfg_pkg::S:mesh_cfg_pkg::P][2:0]               rr_ptr_r;
  logic [mesh_cfg_pkg::S:mesh_cfg_pkg::P][2:0]               gnt_idx;
  logic [mesh_cfg_pkg::S:mesh_cfg_pkg::P]                    gnt_v;
  logic [mesh_cfg_pkg::S:mesh_cfg_pkg::P]                    xfer;
  logic [mesh_cfg_pkg::S:mesh_cfg_pkg::P]                    deq;

  // ----------------------------------------
  // helpers
  // ----------------------------------------

  // XY routing, fix the column first, then the row
  function automatic mesh_cfg_pkg::dir_e route_f(input mesh_pkt_pkg::mesh_pkt_s pkt,
                                                 input mesh_cfg_pkg::x_cord_t  x,
                                                 input mesh_cfg_pkg::y_cord_t  y);
    mesh_cfg_pkg::dir_e dir;
    if (pkt.dest_x > x)
      dir = mesh_cfg_pkg::E;
    else if (pkt.dest_x < x)
      dir = mesh_cfg_pkg::W;
    else if (pkt.dest_y > y)
      dir = mesh_cfg_pkg::S;
    else if (pkt.dest_y < y)
      dir = mesh_cfg_pkg::N;
    else
      dir = mesh_cfg_pkg::P;
    return dir;
  endfunction

  // port index modulo the port count
  function automatic logic [2:0] wrap_f(input logic [3:0] v);
    logic [3:0] w;
    w = (v >= 4'(mesh_cfg_pkg::num_dirs_c)) ? v - 4'(mesh_cfg_pkg::num_dirs_c) : v;
    return w[2:0];
  endfunction

  // ----------------------------------------
  // route and arbitrate
  // ----------------------------------------

  always_comb
  begin
    for (int i = 0; i < mesh_cfg_pkg::num_dirs_c; i++)
    begin
      route_dir[i] = route_f(buf_pkt_r[i], my_x_i, my_y_i);
    end
  end

  // scan inputs starting at the pointer, nearest requester wins
  // scanning backwards lets the nearest one overwrite the rest
  always_comb
  begin
    logic [2:0] cand;
    cand    = '0;
    gnt_v   = '0;
    gnt_idx = '0;
    for (int o = 0; o < mesh_cfg_pkg::num_dirs_c; o++)
    begin
      for (int k = mesh_cfg_pkg::num_dirs_c - 1; k >= 0; k--)
      begin
        cand = wrap_f(4'(rr_ptr_r[o]) + 4'(k));
        if (buf_v_r[cand] && (route_dir[cand] == mesh_cfg_pkg::dir_e'(o)))
        begin
          gnt_v[o]   = 1'b1;
          gnt_idx[o] = cand;
        end
      end
    end
  end

  // outputs come straight from the granted buffer
  always_comb
  begin
    deq = '0;
    for (int o = 0; o < mesh_cfg_pkg::num_dirs_c; o++)
    begin
      fwd_o[o].v   = gnt_v[o];
      fwd_o[o].pkt = buf_pkt_r[gnt_idx[o]];
      xfer[o]      = gnt_v[o] & rdy_i[o];
      if (xfer[o])
        deq[gnt_idx[o]] = 1'b1;
    end
  end

  // a full buffer never accepts, so accept and deq never meet
  assign accept    = {fwd_i[4].v, fwd_i[3].v, fwd_i[2].v, fwd_i[1].v, fwd_i[0].v} & rdy_r;
  assign buf_v_nxt = (buf_v_r & ~deq) | accept;
  assign rdy_o     = rdy_r;

  // ----------------------------------------
  // state
  // ----------------------------------------

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      buf_v_r  <= '0;
      rdy_r    <= '0;
      rr_ptr_r <= '0;
    end
    else
    begin
      buf_v_r <= buf_v_nxt;
      rdy_r   <= ~buf_v_nxt;
      // a stalled output keeps its pointer on the winner,
      // so the offered packet stays put until it moves
      for (int o = 0; o < mesh_cfg_pkg::num_dirs_c; o++)
      begin
        if (xfer[o])
          rr_ptr_r[o] <= wrap_f(4'(gnt_idx[o]) + 4'd1);
        else if (gnt_v[o])
          rr_ptr_r[o] <= gnt_idx[o];
      end
    end
  end

  // buffer payloads
  always_ff @(posedge clk_i)
  begin
    for (int i = 0; i < mesh_cfg_pkg::num_dirs_c; i++)
    begin
      if (accept[i])
        buf_pkt_r[i] <= fwd_i[i].pkt;
    end
  end

endmodule

`default_nettype wire

//--- verilog/mesh_tile.sv
`timescale 1ns/1ps
`default_nettype none

module mesh_tile (
  input  logic                                                      clk_i,
  input  logic                                                      rst_i,
  input  mesh_cfg_pkg::x_cord_t                                     my_x_i,
  input  mesh_cfg_pkg::y_cord_t                                     my_y_i,
  input  mesh_pkt_pkg::link_fwd_s [mesh_cfg_pkg::S:mesh_cfg_pkg::W] link_fwd_i,
  output logic [mesh_cfg_pkg::S:mesh_cfg_pkg::W]                    link_rdy_o,
  output mesh_pkt_pkg::link_fwd_s [mesh_cfg_pkg::S:mesh_cfg_pkg::W] link_fwd_o,
  input  logic [mesh_cfg_pkg::S:mesh_cfg_pkg::W]                    link_rdy_i
);

  // full router port bundles, P goes to the endpoint
  mesh_pkt_pkg::link_fwd_s [mesh_cfg_pkg::S:mesh_cfg_pkg::P] rtr_fwd_in;
  mesh_pkt_pkg::link_fwd_s [mesh_cfg_pkg::S:mesh_cfg_pkg::P] rtr_fwd_out;
  logic [mesh_cfg_pkg::S:mesh_cfg_pkg::P]                    rtr_rdy_in;
  logic [mesh_cfg_pkg::S:mesh_cfg_pkg::P]                    rtr_rdy_out;

  // endpoint side
  mesh_pkt_pkg::link_fwd_s                     ep_in;
  mesh_pkt_pkg::ld_ctrl_s                      ep_ld;
  logic                                        ep_accept;
  logic                                        reply_v_r;
  mesh_pkt_pkg::mesh_pkt_s                     reply_pkt_r;
  logic [mesh_pkt_pkg::data_width_c-1:0]       dmem_r [mesh_cfg_pkg::dmem_words_c];

  // ----------------------------------------
  // router
  // ----------------------------------------

  assign rtr_fwd_in[mesh_cfg_pkg::S:mesh_cfg_pkg::W] = link_fwd_i;
  assign rtr_rdy_in[mesh_cfg_pkg::S:mesh_cfg_pkg::W] = link_rdy_i;
  assign link_fwd_o = rtr_fwd_out[mesh_cfg_pkg::S:mesh_cfg_pkg::W];
  assign link_rdy_o = rtr_rdy_out[mesh_cfg_pkg::S:mesh_cfg_pkg::W];

  // pending reply feeds the local input
  assign rtr_fwd_in[mesh_cfg_pkg::P] = '{v: reply_v_r, pkt: reply_pkt_r};
  // endpoint takes nothing while a reply waits
  assign rtr_rdy_in[mesh_cfg_pkg::P] = ~reply_v_r;

  mesh_router rtr (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .my_x_i (my_x_i),
    .my_y_i (my_y_i),
    .fwd_i  (rtr_fwd_in),
    .rdy_o  (rtr_rdy_out),
    .fwd_o  (rtr_fwd_out),
    .rdy_i  (rtr_rdy_in)
  );

  // ----------------------------------------
  // memory endpoint
  // ----------------------------------------

  assign ep_in     = rtr_fwd_out[mesh_cfg_pkg::P];
  assign ep_accept = ep_in.v & ~reply_v_r;
  // load view of the payload word
  assign ep_ld     = ep_in.pkt.payload.ld;

  // stores land in the accept cycle
  always_ff @(posedge clk_i)
  begin
    if (ep_accept && (ep_in.pkt.op == mesh_pkt_pkg::op_store))
      dmem_r[ep_in.pkt.addr] <= ep_in.pkt.payload.data;
  end

  // reply valid, dropped once the router takes it
  // stray replies are simply consumed
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      reply_v_r <= 1'b0;
    else if (ep_accept && (ep_in.pkt.op == mesh_pkt_pkg::op_load))
      reply_v_r <= 1'b1;
    else if (reply_v_r && rtr_rdy_out[mesh_cfg_pkg::P])
      reply_v_r <= 1'b0;
  end

  // reply goes back to where the load asked
  always_ff @(posedge clk_i)
  begin
    if (ep_accept && (ep_in.pkt.op == mesh_pkt_pkg::op_load))
    begin
      reply_pkt_r.op           <= mesh_pkt_pkg::op_reply;
      reply_pkt_r.dest_x       <= ep_ld.reply_x;
      reply_pkt_r.dest_y       <= ep_ld.reply_y;
      reply_pkt_r.addr         <= ep_in.pkt.addr;
      reply_pkt_r.load_id      <= ep_ld.load_id;
      reply_pkt_r.payload.data <= dmem_r[ep_in.pkt.addr];
    end
  end

endmodule

`default_nettype wire

//--- verilog/manycore_array.sv
`timescale 1ns/1ps
`default_nettype none

module manycore_array (
  input  logic                                                       clk_i,
  input  logic                                                       rst_i,
  input  mesh_pkt_pkg::link_fwd_s [mesh_cfg_pkg::num_cols_c-1:0]     io_fwd_i,
  output logic [mesh_cfg_pkg::num_cols_c-1:0]                        io_rdy_o,
  output mesh_pkt_pkg::link_fwd_s [mesh_cfg_pkg::num_cols_c-1:0]     io_fwd_o,
  input  logic [mesh_cfg_pkg::num_cols_c-1:0]                        io_rdy_i
);

  // reset delayed by two flops before any node sees it
  logic rst_r;
  logic rst_rr;

  // per node mesh links, indexed [row][col][dir]
  // node_out is what a node sends toward dir, node_in what it receives from dir
  mesh_pkt_pkg::link_fwd_s [mesh_cfg_pkg::num_rows_c-1:0][mesh_cfg_pkg::num_cols_c-1:0]
                           [mesh_cfg_pkg::S:mesh_cfg_pkg::W] node_out;
  mesh_pkt_pkg::link_fwd_s [mesh_cfg_pkg::num_rows_c-1:0][mesh_cfg_pkg::num_cols_c-1:0]
                           [mesh_cfg_pkg::S:mesh_cfg_pkg::W] node_in;
  // node_rdy_out is a node's ready on its input, node_rdy_in the ready it sees on an output
  logic [mesh_cfg_pkg::num_rows_c-1:0][mesh_cfg_pkg::num_cols_c-1:0]
        [mesh_cfg_pkg::S:mesh_cfg_pkg::W] node_rdy_out;
  logic [mesh_cfg_pkg::num_rows_c-1:0][mesh_cfg_pkg::num_cols_c-1:0]
        [mesh_cfg_pkg::S:mesh_cfg_pkg::W] node_rdy_in;

  always_ff @(posedge clk_i)
  begin
    rst_r  <= rst_i;
    rst_rr <= rst_r;
  end

  // ----------------------------------------
  // i/o row routers
  // ----------------------------------------

  for (genvar c = 0; c < mesh_cfg_pkg::num_cols_c; c++)
  begin : io
    mesh_pkt_pkg::link_fwd_s [mesh_cfg_pkg::S:mesh_cfg_pkg::P] rtr_fwd_in;
    mesh_pkt_pkg::link_fwd_s [mesh_cfg_pkg::S:mesh_cfg_pkg::P] rtr_fwd_out;
    logic [mesh_cfg_pkg::S:mesh_cfg_pkg::P]                    rtr_rdy_in;
    logic [mesh_cfg_pkg::S:mesh_cfg_pkg::P]                    rtr_rdy_out;

    // local port is the chip i/o link
    assign rtr_fwd_in[mesh_cfg_pkg::P] = io_fwd_i[c];
    assign rtr_rdy_in[mesh_cfg_pkg::P] = io_rdy_i[c];
    assign io_fwd_o[c] = rtr_fwd_out[mesh_cfg_pkg::P];
    assign io_rdy_o[c] = rtr_rdy_out[mesh_cfg_pkg::P];

    assign rtr_fwd_in[mesh_cfg_pkg::S:mesh_cfg_pkg::W] = node_in[mesh_cfg_pkg::io_row_c][c];
    assign rtr_rdy_in[mesh_cfg_pkg::S:mesh_cfg_pkg::W] = node_rdy_in[mesh_cfg_pkg::io_row_c][c];
    assign node_out[mesh_cfg_pkg::io_row_c][c] = rtr_fwd_out[mesh_cfg_pkg::S:mesh_cfg_pkg::W];
    assign node_rdy_out[mesh_cfg_pkg::io_row_c][c] = rtr_rdy_out[mesh_cfg_pkg::S:mesh_cfg_pkg::W];

    mesh_router io_router (
      .clk_i  (clk_i),
      .rst_i  (rst_rr),
      .my_x_i (mesh_cfg_pkg::x_cord_t'(c)),
      .my_y_i (mesh_cfg_pkg::y_cord_t'(mesh_cfg_pkg::io_row_c)),
      .fwd_i  (rtr_fwd_in),
      .rdy_o  (rtr_rdy_out),
      .fwd_o  (rtr_fwd_out),
      .rdy_i  (rtr_rdy_in)
    );
  end

  // ----------------------------------------
  // compute tiles
  // ----------------------------------------

  for (genvar r = mesh_cfg_pkg::io_row_c + 1; r < mesh_cfg_pkg::num_rows_c; r++)
  begin : y
    for (genvar c = 0; c < mesh_cfg_pkg::num_cols_c; c++)
    begin : x
      mesh_tile tile (
        .clk_i      (clk_i),
        .rst_i      (rst_rr),
        .my_x_i     (mesh_cfg_pkg::x_cord_t'(c)),
        .my_y_i     (mesh_cfg_pkg::y_cord_t'(r)),
        .link_fwd_i (node_in[r][c]),
        .link_rdy_o (node_rdy_out[r][c]),
        .link_fwd_o (node_out[r][c]),
        .link_rdy_i (node_rdy_in[r][c])
      );
    end
  end

  // ----------------------------------------
  // mesh stitching
  // ----------------------------------------

  // outer edges see an idle link and a ready of 0
  for (genvar r = 0; r < mesh_cfg_pkg::num_rows_c; r++)
  begin : stitch_y
    for (genvar c = 0; c < mesh_cfg_pkg::num_cols_c; c++)
    begin : stitch_x
      if (c == 0)
      begin : w_edge
        assign node_in[r][c][mesh_cfg_pkg::W]     = '0;
        assign node_rdy_in[r][c][mesh_cfg_pkg::W] = 1'b0;
      end
      else
      begin : w_link
        assign node_in[r][c][mesh_cfg_pkg::W]     = node_out[r][c-1][mesh_cfg_pkg::E];
        assign node_rdy_in[r][c][mesh_cfg_pkg::W] = node_rdy_out[r][c-1][mesh_cfg_pkg::E];
      end

      if (c == mesh_cfg_pkg::num_cols_c - 1)
      begin : e_edge
        assign node_in[r][c][mesh_cfg_pkg::E]     = '0;
        assign node_rdy_in[r][c][mesh_cfg_pkg::E] = 1'b0;
      end
      else
      begin : e_link
        assign node_in[r][c][mesh_cfg_pkg::E]     = node_out[r][c+1][mesh_cfg_pkg::W];
        assign node_rdy_in[r][c][mesh_cfg_pkg::E] = node_rdy_out[r][c+1][mesh_cfg_pkg::W];
      end

      // north of row 0 is off chip
      if (r == 0)
      begin : n_edge
        assign node_in[r][c][mesh_cfg_pkg::N]     = '0;
        assign node_rdy_in[r][c][mesh_cfg_pkg::N] = 1'b0;
      end
      else
      begin : n_link
        assign node_in[r][c][mesh_cfg_pkg::N]     = node_out[r-1][c][mesh_cfg_pkg::S];
        assign node_rdy_in[r][c][mesh_cfg_pkg::N] = node_rdy_out[r-1][c][mesh_cfg_pkg::S];
      end

      if (r == mesh_cfg_pkg::num_rows_c - 1)
      begin : s_edge
        assign node_in[r][c][mesh_cfg_pkg::S]     = '0;
        assign node_rdy_in[r][c][mesh_cfg_pkg::S] = 1'b0;
      end
      else
      begin : s_link
        assign node_in[r][c][mesh_cfg_pkg::S]     = node_out[r+1][c][mesh_cfg_pkg::N];
        assign node_rdy_in[r][c][mesh_cfg_pkg::S] = node_rdy_out[r+1][c][mesh_cfg_pkg::N];
      end
    end
  end

endmodule

`default_nettype wire

//--- sim/clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
  output logic clk_o,
  output logic rst_o
);

  // 40 ns period
  initial
  begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

  // reset held for the first 5 rising edges
  initial
  begin
    rst_o = 1'b1;
    repeat (5) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

`default_nettype wire

//--- sim/manycore_array_props.sv
`timescale 1ns/1ps
`default_nettype none

module manycore_array_props (
  input logic                                                   clk_i,
  input logic                                                   rst_i,
  input mesh_pkt_pkg::link_fwd_s [mesh_cfg_pkg::num_cols_c-1:0] in_fwd_i,
  input logic [mesh_cfg_pkg::num_cols_c-1:0]                    in_rdy_i,
  input mesh_pkt_pkg::link_fwd_s [mesh_cfg_pkg::num_cols_c-1:0] out_fwd_i,
  input logic [mesh_cfg_pkg::num_cols_c-1:0]                    out_rdy_i,
  input mesh_pkt_pkg::link_fwd_s [mesh_cfg_pkg::num_rows_c-1:0][mesh_cfg_pkg::num_cols_c-1:0]
                                 [mesh_cfg_pkg::S:mesh_cfg_pkg::W] node_out_i
);

  // count of failed assertions
  int   assert_fails = 0;
  // any node driving a valid off the mesh
  logic edge_v;

  always_comb
  begin
    edge_v = 1'b0;
    for (int r = 0; r < mesh_cfg_pkg::num_rows_c; r++)
    begin
      edge_v = edge_v | node_out_i[r][0][mesh_cfg_pkg::W].v;
      edge_v = edge_v | node_out_i[r][mesh_cfg_pkg::num_cols_c-1][mesh_cfg_pkg::E].v;
    end
    for (int c = 0; c < mesh_cfg_pkg::num_cols_c; c++)
    begin
      edge_v = edge_v | node_out_i[0][c][mesh_cfg_pkg::N].v;
      edge_v = edge_v | node_out_i[mesh_cfg_pkg::num_rows_c-1][c][mesh_cfg_pkg::S].v;
    end
  end

  // ----------------------------------------
  // per column i/o link rules
  // ----------------------------------------

  for (genvar c = 0; c < mesh_cfg_pkg::num_cols_c; c++)
  begin : col
    // refused packet into the mesh is held
    assert property (@(posedge clk_i) disable iff (rst_i !== 1'b0)
      in_fwd_i[c].v && !in_rdy_i[c] |=> in_fwd_i[c].v && $stable(in_fwd_i[c].pkt))
    else
    begin
      $error("io input %0d changed a packet that was not taken", c);
      assert_fails++;
    end

    // refused packet out of the mesh is held
    assert property (@(posedge clk_i) disable iff (rst_i !== 1'b0)
      out_fwd_i[c].v && !out_rdy_i[c] |=> out_fwd_i[c].v && $stable(out_fwd_i[c].pkt))
    else
    begin
      $error("io output %0d changed a packet that was not taken", c);
      assert_fails++;
    end

    // nodes under reset offer nothing and take nothing
    assert property (@(posedge clk_i) rst_i |=> !out_fwd_i[c].v && !in_rdy_i[c])
    else
    begin
      $error("io column %0d active during pipelined reset", c);
      assert_fails++;
    end
  end

  // XY routing never points off the mesh
  assert property (@(posedge clk_i) disable iff (rst_i !== 1'b0) !edge_v)
  else
  begin
    $error("valid raised toward an outer mesh edge");
    assert_fails++;
  end

endmodule

bind manycore_array manycore_array_props props_inst (
  .clk_i      (clk_i),
  .rst_i      (rst_rr),
  .in_fwd_i   (io_fwd_i),
  .in_rdy_i   (io_rdy_o),
  .out_fwd_i  (io_fwd_o),
  .out_rdy_i  (io_rdy_i),
  .node_out_i (node_out)
);

`default_nettype wire

//--- sim/manycore_array_tb.sv
`timescale 1ns/1ps
`default_nettype none

module manycore_array_tb;

  // wait limit in cycles for every handshake loop
  localparam int tmo_c = 200;

  // one stimulus row
  // bp rows go out while the outputs are stalled
  typedef struct packed {
    logic                    bp;
    logic [0:0]              inj_col;
    mesh_pkt_pkg::mesh_pkt_s pkt;
    logic                    exp_v;
    logic [0:0]              exp_col;
    mesh_pkt_pkg::mesh_pkt_s exp_pkt;
  } entry_s;

  logic                                                   clk;
  logic                                                   rst;
  mesh_pkt_pkg::link_fwd_s [mesh_cfg_pkg::num_cols_c-1:0] io_fwd_i;
  logic [mesh_cfg_pkg::num_cols_c-1:0]                    io_rdy_o;
  mesh_pkt_pkg::link_fwd_s [mesh_cfg_pkg::num_cols_c-1:0] io_fwd_o;
  logic [mesh_cfg_pkg::num_cols_c-1:0]                    io_rdy_i;

  entry_s      tbl[$];
  int          pending[$];
  int          errors;
  int          timeouts;
  int          afails;
  logic [31:0] lcg_state;
  // expected contents of each tile memory
  // row 0 has no memory
  logic [31:0] mem_model [mesh_cfg_pkg::num_rows_c][mesh_cfg_pkg::num_cols_c]
                         [mesh_cfg_pkg::dmem_words_c];

  clock_gen clk_gen (
    .clk_o (clk),
    .rst_o (rst)
  );

  manycore_array manycore_array_inst (
    .clk_i    (clk),
    .rst_i    (rst),
    .io_fwd_i (io_fwd_i),
    .io_rdy_o (io_rdy_o),
    .io_fwd_o (io_fwd_o),
    .io_rdy_i (io_rdy_i)
  );

  // ----------------------------------------
  // helpers
  // ----------------------------------------

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_val(input logic [63:0] got, input logic [63:0] exp, input string msg);
    if (got !== exp)
    begin
      errors++;
      $display("CHECK FAILED at %0d ns: %s, got %h, expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic add_store(input int col, input int x, input int y, input int a);
    entry_s e;
    lcg_state = lcg_next(lcg_state);
    mem_model[y][x][a] = lcg_state;
    e = '0;
    e.inj_col = 1'(col);
    e.pkt.op = mesh_pkt_pkg::op_store;
    e.pkt.dest_x = 1'(x);
    e.pkt.dest_y = 2'(y);
    e.pkt.addr = 4'(a);
    e.pkt.payload.data = lcg_state;
    tbl.push_back(e);
  endtask

  // reply expected on column rx with whatever the model holds
  task automatic add_load(input int col, input int x, input int y, input int a, input int id,
                          input int rx, input logic bp);
    entry_s e;
    e = '0;
    e.bp = bp;
    e.inj_col = 1'(col);
    e.pkt.op = mesh_pkt_pkg::op_load;
    e.pkt.dest_x = 1'(x);
    e.pkt.dest_y = 2'(y);
    e.pkt.addr = 4'(a);
    e.pkt.payload.ld.reply_x = 1'(rx);
    e.pkt.payload.ld.reply_y = 2'(mesh_cfg_pkg::io_row_c);
    e.pkt.payload.ld.load_id = 5'(id);
    e.exp_v = 1'b1;
    e.exp_col = 1'(rx);
    e.exp_pkt.op = mesh_pkt_pkg::op_reply;
    e.exp_pkt.dest_x = 1'(rx);
    e.exp_pkt.dest_y = 2'(mesh_cfg_pkg::io_row_c);
    e.exp_pkt.addr = 4'(a);
    e.exp_pkt.load_id = 5'(id);
    e.exp_pkt.payload.data = mem_model[y][x][a];
    tbl.push_back(e);
  endtask

  // packet for the other i/o router leaves there untouched
  task automatic add_pass(input int col);
    entry_s e;
    lcg_state = lcg_next(lcg_state);
    e = '0;
    e.inj_col = 1'(col);
    e.pkt.op = mesh_pkt_pkg::op_store;
    e.pkt.dest_x = 1'(1 - col);
    e.pkt.dest_y = 2'(mesh_cfg_pkg::io_row_c);
    e.pkt.addr = lcg_state[3:0];
    e.pkt.payload.data = lcg_state;
    e.exp_v = 1'b1;
    e.exp_col = 1'(1 - col);
    e.exp_pkt = e.pkt;
    tbl.push_back(e);
  endtask

  task automatic build_table();
    // store then load at every tile and address
    for (int y = 1; y < mesh_cfg_pkg::num_rows_c; y++)
      for (int x = 0; x < mesh_cfg_pkg::num_cols_c; x++)
        for (int a = 0; a < mesh_cfg_pkg::dmem_words_c; a++)
        begin
          add_store(a % 2, x, y, a);
          add_load(a % 2, x, y, a, a + 16 * x, a % 2, 1'b0);
        end
    // injected at column 0 and answered on column 1
    add_load(0, 0, 1, 3, 20, 1, 1'b0);
    add_load(0, 1, 2, 9, 21, 1, 1'b0);
    // same address in all tiles before one tile is rewritten
    for (int y = 1; y < mesh_cfg_pkg::num_rows_c; y++)
      for (int x = 0; x < mesh_cfg_pkg::num_cols_c; x++)
        add_store(0, x, y, 7);
    for (int y = 1; y < mesh_cfg_pkg::num_rows_c; y++)
      for (int x = 0; x < mesh_cfg_pkg::num_cols_c; x++)
        add_load(0, x, y, 7, 10 + 2 * y + x, 0, 1'b0);
    add_store(0, 1, 1, 7);
    for (int y = 1; y < mesh_cfg_pkg::num_rows_c; y++)
      for (int x = 0; x < mesh_cfg_pkg::num_cols_c; x++)
        add_load(0, x, y, 7, 24 + 2 * y + x, 0, 1'b0);
    add_pass(0);
    add_pass(1);
    // burst to one tile
    // replies keep issue order
    for (int a = 1; a <= 3; a++)
      add_load(0, 1, 2, a, 28 + a, 1, 1'b1);
  endtask

  // ----------------------------------------
  // link handshakes
  // ----------------------------------------

  // hold valid until ready is seen
  // the transfer lands on the next edge
  task automatic inject(input entry_s e);
    int n;
    n = 0;
    @(posedge clk);
    io_fwd_i[e.inj_col] <= '{v: 1'b1, pkt: e.pkt};
    @(negedge clk);
    while (!io_rdy_o[e.inj_col] && n < tmo_c)
    begin
      n++;
      @(negedge clk);
    end
    if (!io_rdy_o[e.inj_col])
    begin
      timeouts++;
      $display("timeout at %0d ns: column %0d never took a packet", $time, e.inj_col);
    end
    @(posedge clk);
    io_fwd_i[e.inj_col] <= '0;
  endtask

  task automatic collect(input entry_s e);
    int         n;
    logic [0:0] other;
    n = 0;
    other = ~e.exp_col;
    @(negedge clk);
    while (!(io_fwd_o[e.exp_col].v && io_rdy_i[e.exp_col]) && n < tmo_c)
    begin
      check_val(64'(io_fwd_o[other].v), 64'd0, "valid on the wrong column");
      n++;
      @(negedge clk);
    end
    if (io_fwd_o[e.exp_col].v && io_rdy_i[e.exp_col])
    begin
      check_val(64'(io_fwd_o[e.exp_col].pkt), 64'(e.exp_pkt), "output packet");
      check_val(64'(io_fwd_o[other].v), 64'd0, "valid on the wrong column");
      @(posedge clk);
    end
    else
    begin
      timeouts++;
      $display("timeout at %0d ns: nothing came out on column %0d", $time, e.exp_col);
    end
  endtask

  // release the stalled outputs and take the queued replies in order
  task automatic drain();
    if (pending.size() > 0)
    begin
      repeat (20) @(posedge clk);
      io_rdy_i <= '1;
      while (pending.size() > 0)
        collect(tbl[pending.pop_front()]);
    end
  endtask

  task automatic check_idle();
    for (int c = 0; c < mesh_cfg_pkg::num_cols_c; c++)
      check_val(64'(io_fwd_o[c].v), 64'd0, "io_fwd_o valid in reset");
    check_val(64'(io_rdy_o), 64'd0, "io_rdy_o in reset");
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------

  initial
  begin
    int n;
    errors = 0;
    timeouts = 0;
    lcg_state = 32'hd7e7;
    io_fwd_i = '0;
    io_rdy_i = '1;
    build_table();

    // node state is unknown until the reset pipeline fills
    repeat (3) @(posedge clk);
    @(negedge clk);
    n = 0;
    while (rst && n < tmo_c)
    begin
      check_idle();
      n++;
      @(negedge clk);
    end
    repeat (2)
    begin
      check_idle();
      @(negedge clk);
    end
    n = 0;
    while (io_rdy_o !== '1 && n < tmo_c)
    begin
      n++;
      @(negedge clk);
    end
    if (io_rdy_o !== '1)
    begin
      timeouts++;
      $display("timeout at %0d ns: io_rdy_o never rose after reset", $time);
    end

    foreach (tbl[i])
    begin
      if (tbl[i].bp)
      begin
        if (pending.size() == 0)
        begin
          @(posedge clk);
          io_rdy_i <= '0;
        end
        inject(tbl[i]);
        pending.push_back(i);
      end
      else
      begin
        drain();
        inject(tbl[i]);
        if (tbl[i].exp_v)
          collect(tbl[i]);
      end
    end
    drain();

    // nothing may come out once every expected packet was taken
    repeat (10)
    begin
      @(negedge clk);
      for (int c = 0; c < mesh_cfg_pkg::num_cols_c; c++)
        check_val(64'(io_fwd_o[c].v), 64'd0, "extra packet after the last reply");
    end
    afails = manycore_array_inst.props_inst.assert_fails;
    $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
             errors, timeouts, afails);
    if (errors == 0 && timeouts == 0 && afails == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- manycore_mesh.f
verilog/mesh_cfg_pkg.sv
verilog/mesh_pkt_pkg.sv
verilog/mesh_router.sv
verilog/mesh_tile.sv
verilog/manycore_array.sv
sim/clock_gen.sv
sim/manycore_array_props.sv
sim/manycore_array_tb.sv
